/* rtl/tile_defines.svh */
/*
 * Width, bank geometry and address map macros for the memory tile.
 * Include this file wherever one of the TILE_* constants is needed.
 */

`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

`define TILE_ADDR_W        32
`define TILE_DATA_W        32

`define TILE_N_BANKS       4    // Word interleaved L1 banks
`define TILE_N_WORDS_BANK  256

`define TILE_L1_START      (32'h1000_0000)
`define TILE_L1_END        (32'h1000_1000)  // Exclusive, 4 KiB
`define TILE_L2_START      (32'h8000_0000)
`define TILE_L2_END        (32'h9000_0000)  // Exclusive

`define TILE_MAX_TRANS     2    // Outstanding demux transactions

`endif

/* rtl/tile_pkg.sv */
/*
 * Shared types of the memory tile: bus vectors, L1 address fields and
 * the target encoding of the core data demux.
 */

`include "tile_defines.svh"

package tile_pkg;

  typedef logic [`TILE_ADDR_W-1:0]   addr_t;  // Byte address
  typedef logic [`TILE_DATA_W-1:0]   data_t;
  typedef logic [`TILE_DATA_W/8-1:0] be_t;    // One bit per byte lane

  // Address bits 3..2 pick the bank, bits 11..4 the word inside it
  typedef logic [$clog2(`TILE_N_BANKS)-1:0]      bank_sel_t;
  typedef logic [$clog2(`TILE_N_WORDS_BANK)-1:0] word_idx_t;

  typedef enum logic [1:0] {
    TGT_L1,   // Local scratchpad
    TGT_L2,   // External port
    TGT_ERR   // Decode error responder
  } target_e;

endpackage

/* rtl/tile_intf.sv */
/*
 * Memory request interface with the req/gnt/rvalid handshake, and the
 * single port SRAM bank interface between interconnect and banks.
 */

`timescale 1ns/100ps

interface mem_req_if;
  import tile_pkg::*;

  logic  req;
  logic  gnt;
  addr_t addr;
  logic  we;
  be_t   be;
  data_t wdata;
  logic  rvalid;  // One pulse per transfer, in order
  data_t rdata;
  logic  err;

  modport initiator (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport target (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );
endinterface

interface sram_bank_if;
  import tile_pkg::*;

  logic      en;
  logic      we;
  be_t       be;
  word_idx_t idx;
  data_t     wdata;
  data_t     rdata;  // Valid the cycle after an enabled read

  modport ctrl (output en, we, be, idx, wdata, input rdata);
  modport mem  (input en, we, be, idx, wdata, output rdata);
endinterface

/* rtl/l1_spm_bank.sv */
/*
 * One L1 scratchpad bank: single port SRAM with byte enables and one
 * cycle of read latency. Contents start at zero in simulation.
 */

`timescale 1ns/100ps

`include "tile_defines.svh"

module l1_spm_bank (
  input  logic    clk_i,
  sram_bank_if.mem bank_i
);
  import tile_pkg::*;

  localparam int unsigned NBytes = `TILE_DATA_W / 8;

  data_t mem_q [`TILE_N_WORDS_BANK] = '{default: '0};
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (bank_i.en) begin
      if (bank_i.we) begin
        for (int k = 0; k < NBytes; k++) begin
          if (bank_i.be[k]) begin
            mem_q[bank_i.idx][8*k +: 8] <= bank_i.wdata[8*k +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[bank_i.idx];  // Held until the next read
      end
    end
  end

  assign bank_i.rdata = rdata_q;

endmodule

/* rtl/l1_interconnect.sv */
/*
 * L1 interconnect for two initiators, core (index 0) and DMA (index 1),
 * onto the word interleaved banks. Each bank has its own round-robin
 * pointer. Read data returns one cycle after the grant.
 */

`timescale 1ns/100ps

`include "tile_defines.svh"

module l1_interconnect (
  input  logic      clk_i,
  input  logic      rst_ni,
  mem_req_if.target core_i,
  mem_req_if.target dma_i,
  sram_bank_if.ctrl banks_o [`TILE_N_BANKS]
);
  import tile_pkg::*;

  localparam int unsigned NInit   = 2;
  localparam int unsigned BankW   = $clog2(`TILE_N_BANKS);
  localparam int unsigned IdxW    = $clog2(`TILE_N_WORDS_BANK);
  localparam int unsigned BankLsb = $clog2(`TILE_DATA_W / 8);  // Skip byte offset
  localparam int unsigned IdxLsb  = BankLsb + BankW;

  logic [NInit-1:0] init_req;
  logic [NInit-1:0] init_we;
  logic [NInit-1:0] init_gnt;
  logic [NInit-1:0] rvalid_q;
  bank_sel_t        init_bank  [NInit];
  word_idx_t        init_idx   [NInit];
  be_t              init_be    [NInit];
  data_t            init_wdata [NInit];
  bank_sel_t        bank_q     [NInit];  // Bank granted last cycle
  logic [NInit-1:0] win        [`TILE_N_BANKS];
  data_t            bank_rdata [`TILE_N_BANKS];

  // Gather both initiators into arrays
  assign init_req = {dma_i.req, core_i.req};
  assign init_we  = {dma_i.we, core_i.we};

  assign init_bank[0]  = core_i.addr[BankLsb +: BankW];
  assign init_bank[1]  = dma_i.addr[BankLsb +: BankW];
  assign init_idx[0]   = core_i.addr[IdxLsb +: IdxW];
  assign init_idx[1]   = dma_i.addr[IdxLsb +: IdxW];
  assign init_be[0]    = core_i.be;
  assign init_be[1]    = dma_i.be;
  assign init_wdata[0] = core_i.wdata;
  assign init_wdata[1] = dma_i.wdata;

  for (genvar b = 0; b < `TILE_N_BANKS; b++) begin : g_bank
    logic [NInit-1:0] hit;
    logic             rr_q;  // 0 favors core, 1 favors DMA
    logic             sel;

    for (genvar i = 0; i < NInit; i++) begin : g_hit
      assign hit[i] = init_req[i] && (init_bank[i] == bank_sel_t'(b));
    end

    assign win[b][0] = hit[0] && (!hit[1] || !rr_q);
    assign win[b][1] = hit[1] && (!hit[0] || rr_q);
    assign sel       = win[b][1];

    assign banks_o[b].en    = |hit;  // Some initiator always wins
    assign banks_o[b].we    = init_we[sel];
    assign banks_o[b].be    = init_be[sel];
    assign banks_o[b].idx   = init_idx[sel];
    assign banks_o[b].wdata = init_wdata[sel];
    assign bank_rdata[b]    = banks_o[b].rdata;

    // After a conflict the loser gets priority
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= 1'b0;
      end else if (&hit) begin
        rr_q <= win[b][0];
      end
    end
  end

  always_comb begin
    init_gnt = '0;
    for (int b = 0; b < `TILE_N_BANKS; b++) begin
      init_gnt = init_gnt | win[b];
    end
  end

  assign core_i.gnt = init_gnt[0];
  assign dma_i.gnt  = init_gnt[1];

  // Return path, writes get an rvalid too
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= init_gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NInit; i++) begin
      if (init_gnt[i]) begin
        bank_q[i] <= init_bank[i];
      end
    end
  end

  assign core_i.rvalid = rvalid_q[0];
  assign core_i.rdata  = bank_rdata[bank_q[0]];
  assign core_i.err    = 1'b0;
  assign dma_i.rvalid  = rvalid_q[1];
  assign dma_i.rdata   = bank_rdata[bank_q[1]];
  assign dma_i.err     = 1'b0;

endmodule

/* rtl/data_addr_demux.sv */
/*
 * Core data port demux. Decodes each request into L1, L2 or a decode
 * error, tracks the outstanding transactions and steers their responses
 * back in order. A request to a new target waits until the old drains.
 */

`timescale 1ns/100ps

`include "tile_defines.svh"

module data_addr_demux (
  input  logic         clk_i,
  input  logic         rst_ni,
  mem_req_if.target    core_i,
  mem_req_if.initiator l1_o,
  mem_req_if.initiator l2_o
);
  import tile_pkg::*;

  localparam int unsigned CntW = $clog2(`TILE_MAX_TRANS + 1);

  target_e         req_tgt;
  target_e         out_tgt_q;    // Common target of outstanding transfers
  logic [CntW-1:0] out_cnt_q;
  logic [CntW-1:0] out_cnt_d;
  logic            hold;
  logic            tgt_gnt;
  logic            xfer;
  logic            rsp_valid;
  logic            rsp_err;
  logic            err_valid_q;  // Error responder, one cycle deep

  // Address decode
  always_comb begin
    if (core_i.addr >= `TILE_L1_START && core_i.addr < `TILE_L1_END) begin
      req_tgt = TGT_L1;
    end else if (core_i.addr >= `TILE_L2_START && core_i.addr < `TILE_L2_END) begin
      req_tgt = TGT_L2;
    end else begin
      req_tgt = TGT_ERR;
    end
  end

  // Switching target with traffic in flight could reorder responses
  assign hold = ((out_cnt_q != '0) && (req_tgt != out_tgt_q)) ||
                (out_cnt_q == CntW'(`TILE_MAX_TRANS));

  // Request side, payload goes to both paths
  assign l1_o.req   = core_i.req && !hold && (req_tgt == TGT_L1);
  assign l1_o.addr  = core_i.addr;
  assign l1_o.we    = core_i.we;
  assign l1_o.be    = core_i.be;
  assign l1_o.wdata = core_i.wdata;

  assign l2_o.req   = core_i.req && !hold && (req_tgt == TGT_L2);
  assign l2_o.addr  = core_i.addr;
  assign l2_o.we    = core_i.we;
  assign l2_o.be    = core_i.be;
  assign l2_o.wdata = core_i.wdata;

  always_comb begin
    case (req_tgt)
      TGT_L1:  tgt_gnt = l1_o.gnt;
      TGT_L2:  tgt_gnt = l2_o.gnt;  // Same cycle pass-through
      default: tgt_gnt = 1'b1;      // Errors are accepted at once
    endcase
  end

  assign core_i.gnt = core_i.req && !hold && tgt_gnt;
  assign xfer       = core_i.req && core_i.gnt;

  // Response side, selected by the outstanding target
  always_comb begin
    case (out_tgt_q)
      TGT_L1: begin
        rsp_valid   = l1_o.rvalid;
        rsp_err     = l1_o.err;
        core_i.rdata = l1_o.rdata;
      end
      TGT_L2: begin
        rsp_valid   = l2_o.rvalid;
        rsp_err     = l2_o.err;
        core_i.rdata = l2_o.rdata;
      end
      default: begin
        rsp_valid   = err_valid_q;
        rsp_err     = 1'b1;
        core_i.rdata = '0;
      end
    endcase
  end

  assign core_i.rvalid = rsp_valid;
  assign core_i.err    = rsp_valid && rsp_err;

  always_comb begin
    out_cnt_d = out_cnt_q;
    if (xfer && !rsp_valid) begin
      out_cnt_d = out_cnt_q + 1'b1;
    end else if (!xfer && rsp_valid) begin
      out_cnt_d = out_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt_q   <= '0;
      out_tgt_q   <= TGT_L1;
      err_valid_q <= 1'b0;
    end else begin
      out_cnt_q   <= out_cnt_d;
      err_valid_q <= xfer && (req_tgt == TGT_ERR);
      if (xfer) begin
        out_tgt_q <= req_tgt;  // Equal to the old one while busy
      end
    end
  end

endmodule

/* rtl/mem_tile.sv */
/*
 * Data memory side of the tile. The core port is split between the
 * L1 scratchpad and the external L2 port; the DMA port shares the L1
 * banks with the core through the local interconnect.
 */

`timescale 1ns/100ps

`include "tile_defines.svh"

module mem_tile (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Core data port
  input  logic            core_req_i,
  output logic            core_gnt_o,
  input  tile_pkg::addr_t core_addr_i,
  input  logic            core_we_i,
  input  tile_pkg::be_t   core_be_i,
  input  tile_pkg::data_t core_wdata_i,
  output logic            core_rvalid_o,
  output tile_pkg::data_t core_rdata_o,
  output logic            core_err_o,
  // DMA port into L1
  input  logic            dma_req_i,
  output logic            dma_gnt_o,
  input  tile_pkg::addr_t dma_addr_i,
  input  logic            dma_we_i,
  input  tile_pkg::be_t   dma_be_i,
  input  tile_pkg::data_t dma_wdata_i,
  output logic            dma_rvalid_o,
  output tile_pkg::data_t dma_rdata_o,
  // External L2 port, tile is initiator
  output logic            l2_req_o,
  input  logic            l2_gnt_i,
  output tile_pkg::addr_t l2_addr_o,
  output logic            l2_we_o,
  output tile_pkg::be_t   l2_be_o,
  output tile_pkg::data_t l2_wdata_o,
  input  logic            l2_rvalid_i,
  input  tile_pkg::data_t l2_rdata_i,
  input  logic            l2_err_i
);

  mem_req_if   core_if ();
  mem_req_if   l2_if ();
  mem_req_if   core_l1 ();
  mem_req_if   dma_l1 ();
  sram_bank_if bank_if [`TILE_N_BANKS] ();

  assign core_if.req   = core_req_i;
  assign core_if.addr  = core_addr_i;
  assign core_if.we    = core_we_i;
  assign core_if.be    = core_be_i;
  assign core_if.wdata = core_wdata_i;
  assign core_gnt_o    = core_if.gnt;
  assign core_rvalid_o = core_if.rvalid;
  assign core_rdata_o  = core_if.rdata;
  assign core_err_o    = core_if.err;

  assign dma_l1.req    = dma_req_i;
  assign dma_l1.addr   = dma_addr_i;  // Interconnect reads bank and word bits only
  assign dma_l1.we     = dma_we_i;
  assign dma_l1.be     = dma_be_i;
  assign dma_l1.wdata  = dma_wdata_i;
  assign dma_gnt_o     = dma_l1.gnt;
  assign dma_rvalid_o  = dma_l1.rvalid;
  assign dma_rdata_o   = dma_l1.rdata;

  assign l2_req_o      = l2_if.req;
  assign l2_addr_o     = l2_if.addr;
  assign l2_we_o       = l2_if.we;
  assign l2_be_o       = l2_if.be;
  assign l2_wdata_o    = l2_if.wdata;
  assign l2_if.gnt     = l2_gnt_i;
  assign l2_if.rvalid  = l2_rvalid_i;
  assign l2_if.rdata   = l2_rdata_i;
  assign l2_if.err     = l2_err_i;

  data_addr_demux i_demux (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .core_i ( core_if ),
    .l1_o   ( core_l1 ),
    .l2_o   ( l2_if   )
  );

  l1_interconnect i_l1_ic (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .core_i  ( core_l1 ),
    .dma_i   ( dma_l1  ),
    .banks_o ( bank_if )
  );

  for (genvar b = 0; b < `TILE_N_BANKS; b++) begin : g_bank
    l1_spm_bank i_bank (
      .clk_i  ( clk_i      ),
      .bank_i ( bank_if[b] )
    );
  end

endmodule

/* test/tb_mem_tile.sv */
/*
 * Testbench for the memory tile. Random core traffic to L1, L2 and
 * unmapped space, plus DMA traffic into L1, is checked against a model
 * of the L1 array and an in-order L2 responder with random delays.
 */

`timescale 1ns/100ps

`include "tile_defines.svh"

module tb_mem_tile;
  import tile_pkg::*;

  localparam int NTrans  = 600;               // Core transfers over all tests
  localparam int Timeout = 4 * NTrans + 200;  // Cycle limit of the run

  typedef struct {
    data_t data;
    logic  err;
    logic  chk;    // Compare rdata
    logic  fixed;  // Response due one cycle after transfer
    int    cycle;  // Transfer cycle, or release cycle for L2
  } rsp_t;

  logic  clk_i;
  logic  rst_ni;
  logic  core_req_i, core_gnt_o, core_we_i, core_rvalid_o, core_err_o;
  addr_t core_addr_i;
  be_t   core_be_i;
  data_t core_wdata_i, core_rdata_o;
  logic  dma_req_i, dma_gnt_o, dma_we_i, dma_rvalid_o;
  addr_t dma_addr_i;
  be_t   dma_be_i;
  data_t dma_wdata_i, dma_rdata_o;
  logic  l2_req_o, l2_gnt_i, l2_we_o, l2_rvalid_i, l2_err_i;
  addr_t l2_addr_o;
  be_t   l2_be_o;
  data_t l2_wdata_o, l2_rdata_i;

  int    seed      = 15619;
  int    cycles    = 0;
  int    gnt_delay = 0;  // L2 cycles left before grant
  int    dma_wait  = 0;
  string test_name = "reset";
  data_t l1_model [1024] = '{default: '0};  // Indexed by address bits 11..2
  data_t l2_mem [addr_t];
  rsp_t  core_exp [$];
  rsp_t  dma_exp [$];
  rsp_t  l2_rsp [$];

  mem_tile DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string what, input data_t exp, input data_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_be(input string what, input be_t exp, input be_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed) & 32'h7fff_ffff;  // Non-negative
    return r % n;
  endfunction

  function automatic logic in_l1(input addr_t a);
    return a >= `TILE_L1_START && a < `TILE_L1_END;
  endfunction

  function automatic logic in_l2(input addr_t a);
    return a >= `TILE_L2_START && a < `TILE_L2_END;
  endfunction

  function automatic addr_t l1_addr(input int words);
    return `TILE_L1_START + addr_t'(rand_below(words) << 2);  // Small range, more reuse
  endfunction

  function automatic addr_t l2_addr();
    addr_t a;
    a = `TILE_L2_START + addr_t'(rand_below(64) << 2);
    if (rand_below(4) == 0) a = a | 32'h0F00_0000;  // Top of the L2 region
    return a;
  endfunction

  function automatic addr_t err_addr();
    case (rand_below(3))
      0:       return `TILE_L1_END + addr_t'(rand_below(1024) << 2);  // Aliases L1 bits
      1:       return `TILE_L2_END + addr_t'(rand_below(1024) << 2);
      default: return 32'h4000_0000 + addr_t'(rand_below(65536) << 2);
    endcase
  endfunction

  function automatic data_t merge_be(input data_t old, input data_t wd, input be_t be);
    data_t m;
    m = old;
    for (int k = 0; k < 4; k++) begin
      if (be[k]) m[8*k +: 8] = wd[8*k +: 8];
    end
    return m;
  endfunction

  // Word after the access, read data for a read
  function automatic data_t l1_apply(input addr_t a, input logic we, input be_t be,
                                     input data_t wd);
    if (we) l1_model[a[11:2]] = merge_be(l1_model[a[11:2]], wd, be);
    return l1_model[a[11:2]];
  endfunction

  function automatic data_t l2_read(input addr_t a);
    addr_t w;
    w = {a[31:2], 2'b00};
    if (l2_mem.exists(w)) return l2_mem[w];
    return {w[15:0], w[31:16]} ^ 32'hA5C3_0F96;  // Fill from the whole address
  endfunction

  function automatic data_t l2_apply(input addr_t a, input logic we, input be_t be,
                                     input data_t wd);
    if (we) l2_mem[{a[31:2], 2'b00}] = merge_be(l2_read(a), wd, be);
    return l2_read(a);
  endfunction

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic core_access(input addr_t a, input logic we);
    core_req_i   = 1'b1;
    core_addr_i  = a;
    core_we_i    = we;
    core_be_i    = be_t'(rand_below(16));
    core_wdata_i = $random(seed);
    @(posedge clk_i);
    while (!core_gnt_o) @(posedge clk_i);
    @(negedge clk_i);
    core_req_i = 1'b0;
  endtask

  task automatic dma_access(input addr_t a, input logic we);
    dma_req_i   = 1'b1;
    dma_addr_i  = a;
    dma_we_i    = we;
    dma_be_i    = be_t'(rand_below(16));
    dma_wdata_i = $random(seed);
    @(posedge clk_i);
    while (!dma_gnt_o) @(posedge clk_i);
    @(negedge clk_i);
    dma_req_i = 1'b0;
  endtask

  // L2 responder, in order, driven on the falling edge
  initial begin
    l2_gnt_i    = 1'b0;
    l2_rvalid_i = 1'b0;
    l2_rdata_i  = '0;
    l2_err_i    = 1'b0;
    forever begin
      @(negedge clk_i);
      l2_gnt_i = (gnt_delay == 0);
      if (l2_rsp.size() != 0 && l2_rsp[0].cycle <= cycles) begin
        l2_rvalid_i = 1'b1;
        l2_rdata_i  = l2_rsp[0].data;
        void'(l2_rsp.pop_front());
      end else begin
        l2_rvalid_i = 1'b0;
        l2_rdata_i  = '0;
      end
    end
  end

  always @(posedge clk_i) begin : monitor
    rsp_t e;
    cycles = cycles + 1;
    if (cycles >= Timeout) begin
      abort_run($sformatf("Timeout after %0d cycles, the traffic did not complete", cycles));
    end else if (rst_ni) begin
      // Responses first, then this cycle's transfers
      if (core_rvalid_o) begin
        if (core_exp.size() == 0) begin
          abort_run("Core rvalid arrived with no transfer outstanding");
        end else begin
          e = core_exp.pop_front();
          check_bit("core err", e.err, core_err_o);
          if (e.chk) check_data("core rdata", e.data, core_rdata_o);
          if (e.fixed && cycles != e.cycle + 1) begin
            abort_run($sformatf("Core rvalid came %0d cycles after its transfer, not 1",
                                cycles - e.cycle));
          end
        end
      end
      if (dma_rvalid_o) begin
        if (dma_exp.size() == 0) begin
          abort_run("DMA rvalid arrived with no transfer outstanding");
        end else begin
          e = dma_exp.pop_front();
          if (e.chk) check_data("dma rdata", e.data, dma_rdata_o);
          if (cycles != e.cycle + 1) begin
            abort_run("DMA rvalid did not come one cycle after its transfer");
          end
        end
      end
      if (core_req_i && core_gnt_o) begin
        e.cycle = cycles;
        e.err   = 1'b0;
        e.chk   = !core_we_i;
        e.fixed = 1'b1;
        if (in_l1(core_addr_i)) begin
          e.data = l1_apply(core_addr_i, core_we_i, core_be_i, core_wdata_i);
        end else if (in_l2(core_addr_i)) begin
          e.fixed = 1'b0;  // Latency set by the responder
          e.data  = l2_read(core_addr_i);
        end else begin
          e.err  = 1'b1;
          e.chk  = 1'b1;
          e.data = '0;
        end
        core_exp.push_back(e);
      end
      if (dma_req_i && dma_gnt_o) begin
        e.cycle = cycles;
        e.chk   = !dma_we_i;
        e.data  = l1_apply(dma_addr_i, dma_we_i, dma_be_i, dma_wdata_i);
        dma_exp.push_back(e);
        dma_wait = 0;
      end else if (dma_req_i) begin
        dma_wait = dma_wait + 1;
        if (dma_wait > 1) abort_run("DMA request was not granted within 2 cycles");
      end
      if (l2_req_o && !in_l2(core_addr_i)) begin
        abort_run("L2 request raised for a core address outside the L2 region");
      end
      if (l2_req_o && l2_gnt_i) begin
        check_addr("l2 addr", core_addr_i, l2_addr_o);
        check_bit("l2 we", core_we_i, l2_we_o);
        check_be("l2 be", core_be_i, l2_be_o);
        if (core_we_i) check_data("l2 wdata", core_wdata_i, l2_wdata_o);
        e.data  = l2_apply(l2_addr_o, l2_we_o, l2_be_o, l2_wdata_o);
        e.cycle = cycles + rand_below(4);  // Latency of 1 to 4 cycles, queue keeps order
        l2_rsp.push_back(e);
        gnt_delay = rand_below(4);
      end else if (l2_req_o && gnt_delay != 0) begin
        gnt_delay = gnt_delay - 1;
      end
    end
  end

  initial begin
    rst_ni       = 1'b0;
    core_req_i   = 1'b0;
    core_addr_i  = '0;
    core_we_i    = 1'b0;
    core_be_i    = '0;
    core_wdata_i = '0;
    dma_req_i    = 1'b0;
    dma_addr_i   = '0;
    dma_we_i     = 1'b0;
    dma_be_i     = '0;
    dma_wdata_i  = '0;
    repeat (8) @(posedge clk_i);
    check_bit("core rvalid in reset", 1'b0, core_rvalid_o);
    check_bit("core err in reset", 1'b0, core_err_o);
    check_bit("dma rvalid in reset", 1'b0, dma_rvalid_o);
    check_bit("l2 req in reset", 1'b0, l2_req_o);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "l1_write_read";
    repeat (80) core_access(l1_addr(128), 1'b1);
    repeat (80) core_access(l1_addr(128), 1'b0);

    test_name = "l2_forward";
    repeat (120) core_access(l2_addr(), rand_below(2) == 1);

    test_name = "decode_error";
    repeat (40) core_access(err_addr(), rand_below(2) == 1);

    test_name = "mixed_order";  // Back to back over all three targets
    repeat (140) begin
      case (rand_below(3))
        0:       core_access(l1_addr(1024), rand_below(2) == 1);
        1:       core_access(l2_addr(), rand_below(2) == 1);
        default: core_access(err_addr(), rand_below(2) == 1);
      endcase
    end

    test_name = "bank_arbitration";  // 16 words, frequent bank conflicts
    fork
      repeat (140) core_access(l1_addr(16), rand_below(2) == 1);
      repeat (140) dma_access(l1_addr(16), rand_below(2) == 1);
    join

    while (core_exp.size() != 0 || dma_exp.size() != 0) @(posedge clk_i);
    @(negedge clk_i);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* all.f */
+incdir+rtl
rtl/tile_pkg.sv
rtl/tile_intf.sv
rtl/l1_spm_bank.sv
rtl/l1_interconnect.sv
rtl/data_addr_demux.sv
rtl/mem_tile.sv
test/tb_mem_tile.sv

/* run.sh */
#!/bin/sh
# Build the memory tile testbench with Verilator and run it.
# The exit status of the simulation binary is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal \
  --top-module tb_mem_tile \
  -f all.f \
  -o sim_mem_tile

./obj_dir/sim_mem_tile
